// ==== hdl/sa_params.svh ====
`ifndef SA_PARAMS_SVH
`define SA_PARAMS_SVH

// ------------------------------
// array geometry
// ------------------------------
`define SA_DIM      4   // rows == columns

// ------------------------------
// datapath widths
// ------------------------------
`define SA_DATA_W   8   // operand lane width
`define SA_ACC_W    32  // accumulator, wraps on overflow

// ------------------------------
// operand bank size
// ------------------------------
`define SA_ADDR_W   4
`define SA_DEPTH    16

`endif

// ==== hdl/sa_pkg.sv ====
`include "sa_params.svh"

package sa_pkg;

    typedef enum logic {
        BANK_LEFT = 1'b0,  // A columns
        BANK_TOP  = 1'b1   // B rows
    } sa_bank_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FEED,
        ST_FLUSH,
        ST_STORE
    } sa_state_e;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [`SA_DIM-1:0][`SA_DATA_W-1:0] sa_vec_t;
    typedef logic [`SA_DIM-1:0][`SA_ACC_W-1:0]  sa_acc_vec_t;
    typedef logic [`SA_DIM-1:0]                 sa_lane_valid_t;

    // ------------------------------
    // request / response structs
    // ------------------------------
    typedef struct packed {
        logic                  en;
        sa_bank_e              bank;
        logic [`SA_ADDR_W-1:0] addr;
        sa_vec_t               data;
    } sa_wr_req_t;

    typedef struct packed {
        logic                start;
        logic [`SA_ADDR_W:0] len;   // 1 .. SA_DEPTH
    } sa_start_t;

    typedef struct packed {
        logic                  en;
        logic [`SA_ADDR_W-1:0] addr;
    } sa_bank_rd_t;

    typedef struct packed {
        sa_lane_valid_t valid;
        sa_vec_t        data;
    } sa_feed_t;

    typedef struct packed {
        logic                  en;
        logic [`SA_ADDR_W-1:0] addr;  // result row
    } sa_rd_req_t;

    typedef struct packed {
        logic        valid;
        sa_acc_vec_t data;
    } sa_rd_rsp_t;

    // last operand needs 2*(DIM-1)+1 cycles to reach the far corner
    localparam int SA_FLUSH_CYCLES = 3 * `SA_DIM;

endpackage

// ==== hdl/sa_operand_bank.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_operand_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_wr_en,
    input  logic [`SA_ADDR_W-1:0] i_wr_addr,
    input  sa_pkg::sa_vec_t       i_wr_data,
    input  sa_pkg::sa_bank_rd_t   i_rd,
    output sa_pkg::sa_feed_t      o_feed
);
    import sa_pkg::*;

    sa_vec_t        mem [`SA_DEPTH];
    sa_vec_t        rd_data;
    logic           rd_vld;
    sa_lane_valid_t lane_vld;
    sa_vec_t        lane_data;

    // ------------------------------
    // storage, one cycle read
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
        if (i_rd.en)
            rd_data <= mem[i_rd.addr];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_vld <= 1'b0;
        else
            rd_vld <= i_rd.en;
    end

    // ------------------------------
    // lane skew, lane g delayed g cycles
    // ------------------------------
    genvar g;
    generate
        for (g = 0; g < `SA_DIM; g++)
        begin : g_lane
            if (g == 0)
            begin : g_direct
                assign lane_vld[g]  = rd_vld;
                assign lane_data[g] = rd_data[g];
            end
            else
            begin : g_skew
                logic [`SA_DATA_W-1:0] sh_data [g];
                logic [g-1:0]          sh_vld;

                always_ff @(posedge clk or negedge rst_n)
                begin
                    if (!rst_n)
                        sh_vld <= '0;
                    else
                    begin
                        sh_vld[0] <= rd_vld;
                        for (int i = 1; i < g; i++)
                            sh_vld[i] <= sh_vld[i-1];
                    end
                end

                always_ff @(posedge clk)
                begin
                    sh_data[0] <= rd_data[g];  // payload, no reset
                    for (int i = 1; i < g; i++)
                        sh_data[i] <= sh_data[i-1];
                end

                assign lane_vld[g]  = sh_vld[g-1];
                assign lane_data[g] = sh_data[g-1];
            end
        end
    endgenerate

    assign o_feed = '{valid: lane_vld, data: lane_data};

endmodule

// ==== hdl/sa_mac_cell.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_mac_cell (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_clear,
    input  logic [`SA_DATA_W-1:0] i_a,
    input  logic [`SA_DATA_W-1:0] i_b,
    input  logic                  i_a_valid,
    input  logic                  i_b_valid,
    output logic [`SA_DATA_W-1:0] o_a,
    output logic [`SA_DATA_W-1:0] o_b,
    output logic                  o_a_valid,
    output logic                  o_b_valid,
    output logic [`SA_ACC_W-1:0]  o_acc
);

    logic [2*`SA_DATA_W-1:0] prod;

    assign prod = i_a * i_b;  // full width product

    // operand forwarding, a right and b down
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_a_valid <= 1'b0;
            o_b_valid <= 1'b0;
        end
        else
        begin
            o_a_valid <= i_a_valid;
            o_b_valid <= i_b_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        o_a <= i_a;
        o_b <= i_b;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_acc <= '0;
        else if (i_clear)
            o_acc <= '0;  // new run
        else if (i_a_valid && i_b_valid)
            o_acc <= o_acc + `SA_ACC_W'(prod);
    end

endmodule

// ==== hdl/sa_mac_grid.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_mac_grid (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_clear,
    input  sa_pkg::sa_feed_t      i_left,
    input  sa_pkg::sa_feed_t      i_top,
    input  logic [`SA_ADDR_W-1:0] i_row_sel,
    output sa_pkg::sa_acc_vec_t   o_row_acc
);
    import sa_pkg::*;

    // mesh wiring, one extra column / row on the far edge
    logic [`SA_DATA_W-1:0] a_bus [`SA_DIM][`SA_DIM+1];
    logic                  a_vld [`SA_DIM][`SA_DIM+1];
    logic [`SA_DATA_W-1:0] b_bus [`SA_DIM+1][`SA_DIM];
    logic                  b_vld [`SA_DIM+1][`SA_DIM];
    sa_acc_vec_t           acc_row [`SA_DIM];

    genvar r, c;
    generate
        for (r = 0; r < `SA_DIM; r++)
        begin : g_row
            assign a_bus[r][0] = i_left.data[r];   // left edge
            assign a_vld[r][0] = i_left.valid[r];
            assign b_bus[0][r] = i_top.data[r];    // top edge
            assign b_vld[0][r] = i_top.valid[r];

            for (c = 0; c < `SA_DIM; c++)
            begin : g_col
                sa_mac_cell u_cell (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .i_clear   (i_clear),
                    .i_a       (a_bus[r][c]),
                    .i_b       (b_bus[r][c]),
                    .i_a_valid (a_vld[r][c]),
                    .i_b_valid (b_vld[r][c]),
                    .o_a       (a_bus[r][c+1]),
                    .o_b       (b_bus[r+1][c]),
                    .o_a_valid (a_vld[r][c+1]),
                    .o_b_valid (b_vld[r+1][c]),
                    .o_acc     (acc_row[r][c])
                );
            end
        end
    endgenerate

    // ------------------------------
    // drain row select
    // ------------------------------
    always_comb
    begin
        o_row_acc = '0;
        for (int i = 0; i < `SA_DIM; i++)
            if (i_row_sel == `SA_ADDR_W'(i))
                o_row_acc = acc_row[i];
    end

endmodule

// ==== hdl/sa_result_bank.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_result_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_st_en,
    input  logic [`SA_ADDR_W-1:0] i_st_addr,
    input  sa_pkg::sa_acc_vec_t   i_st_data,
    input  sa_pkg::sa_rd_req_t    i_rd_req,
    output sa_pkg::sa_rd_rsp_t    o_rd_rsp
);
    import sa_pkg::*;

    localparam int ROW_W = (`SA_DIM > 1) ? $clog2(`SA_DIM) : 1;

    sa_acc_vec_t mem [`SA_DIM];
    sa_acc_vec_t rsp_data;
    logic        rsp_valid;

    always_ff @(posedge clk)
    begin
        if (i_st_en && (i_st_addr < `SA_DIM))
            mem[i_st_addr[ROW_W-1:0]] <= i_st_data;
        if (i_rd_req.en)
        begin
            if (i_rd_req.addr < `SA_DIM)
                rsp_data <= mem[i_rd_req.addr[ROW_W-1:0]];
            else
                rsp_data <= '0;  // no such row
        end
    end

    // response one cycle after request
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= i_rd_req.en;
    end

    assign o_rd_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

// ==== hdl/sa_controller.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sa_pkg::sa_start_t     i_start,
    output sa_pkg::sa_bank_rd_t   o_bank_rd,
    output logic                  o_clear,
    output logic [`SA_ADDR_W-1:0] o_row_sel,
    output logic                  o_st_en,
    output logic                  o_busy,
    output logic                  o_done
);
    import sa_pkg::*;

    localparam int LEN_W   = `SA_ADDR_W + 1;
    localparam int FLUSH_W = $clog2(SA_FLUSH_CYCLES + 1);

    sa_state_e             state;
    logic [LEN_W-1:0]      k_len;      // latched run length
    logic [LEN_W-1:0]      k_in;
    logic [`SA_ADDR_W-1:0] feed_cnt;
    logic [FLUSH_W-1:0]    flush_cnt;
    logic [`SA_ADDR_W-1:0] row_cnt;
    logic                  clear_q;
    logic                  feed_last;
    logic                  flush_last;
    logic                  store_last;

    // keep length inside 1 .. depth
    always_comb
    begin
        if (i_start.len == '0)
            k_in = LEN_W'(1);
        else if (i_start.len > `SA_DEPTH)
            k_in = LEN_W'(`SA_DEPTH);
        else
            k_in = i_start.len;
    end

    assign feed_last  = ({1'b0, feed_cnt} == (k_len - 1'b1));
    assign flush_last = (flush_cnt == FLUSH_W'(SA_FLUSH_CYCLES - 1));
    assign store_last = (row_cnt == `SA_ADDR_W'(`SA_DIM - 1));

    // ------------------------------
    // run FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            k_len     <= '0;
            feed_cnt  <= '0;
            flush_cnt <= '0;
            row_cnt   <= '0;
            clear_q   <= 1'b0;
        end
        else
        begin
            clear_q <= 1'b0;
            case (state)
                ST_IDLE:
                    if (i_start.start)
                    begin
                        state    <= ST_FEED;
                        k_len    <= k_in;
                        feed_cnt <= '0;
                        clear_q  <= 1'b1;  // zero grid before first operand
                    end
                ST_FEED:
                begin
                    feed_cnt <= feed_cnt + 1'b1;
                    if (feed_last)
                    begin
                        state     <= ST_FLUSH;
                        flush_cnt <= '0;
                    end
                end
                ST_FLUSH:
                begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_last)
                    begin
                        state   <= ST_STORE;
                        row_cnt <= '0;
                    end
                end
                ST_STORE:
                begin
                    row_cnt <= row_cnt + 1'b1;
                    if (store_last)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign o_bank_rd = '{en: (state == ST_FEED), addr: feed_cnt};
    assign o_clear   = clear_q;
    assign o_row_sel = row_cnt;
    assign o_st_en   = (state == ST_STORE);
    assign o_done    = (state == ST_STORE) && store_last;     // last row written
    assign o_busy    = (state != ST_IDLE) && !o_done;

endmodule

// ==== hdl/sa_top.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_top (
    input  logic               clk,
    input  logic               rst_n,
    input  sa_pkg::sa_wr_req_t i_wr,
    input  sa_pkg::sa_start_t  i_start,
    input  sa_pkg::sa_rd_req_t i_rd_req,
    output sa_pkg::sa_rd_rsp_t o_rd_rsp,
    output logic               o_busy,
    output logic               o_done
);
    import sa_pkg::*;

    logic                  busy;
    logic                  wr_ok;
    logic                  left_wr_en;
    logic                  top_wr_en;
    sa_bank_rd_t           bank_rd;
    sa_feed_t              left_feed;
    sa_feed_t              top_feed;
    logic                  grid_clear;
    logic [`SA_ADDR_W-1:0] row_sel;
    logic                  st_en;
    sa_acc_vec_t           row_acc;

    // ------------------------------
    // write decode, dropped while busy
    // ------------------------------
    assign wr_ok      = i_wr.en && !busy;
    assign left_wr_en = wr_ok && (i_wr.bank == BANK_LEFT);
    assign top_wr_en  = wr_ok && (i_wr.bank == BANK_TOP);

    sa_operand_bank u_left_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (left_wr_en),
        .i_wr_addr (i_wr.addr),
        .i_wr_data (i_wr.data),
        .i_rd      (bank_rd),
        .o_feed    (left_feed)
    );

    sa_operand_bank u_top_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (top_wr_en),
        .i_wr_addr (i_wr.addr),
        .i_wr_data (i_wr.data),
        .i_rd      (bank_rd),   // same stream as left
        .o_feed    (top_feed)
    );

    sa_mac_grid u_grid (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_clear   (grid_clear),
        .i_left    (left_feed),
        .i_top     (top_feed),
        .i_row_sel (row_sel),
        .o_row_acc (row_acc)
    );

    sa_result_bank u_result_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_st_en   (st_en),
        .i_st_addr (row_sel),
        .i_st_data (row_acc),
        .i_rd_req  (i_rd_req),
        .o_rd_rsp  (o_rd_rsp)
    );

    sa_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (i_start),
        .o_bank_rd (bank_rd),
        .o_clear   (grid_clear),
        .o_row_sel (row_sel),
        .o_st_en   (st_en),
        .o_busy    (busy),
        .o_done    (o_done)
    );

    assign o_busy = busy;

endmodule

// ==== sim/sa_tb.sv ====
`timescale 1ns/100ps
`include "sa_params.svh"

module sa_tb;
    import sa_pkg::*;

    localparam int RUN_TIMEOUT  = 200;  // cycles allowed for one run
    localparam int READ_TIMEOUT = 8;
    localparam int LEN_W        = `SA_ADDR_W + 1;

    logic        clk;
    logic        rst_n;
    sa_wr_req_t  wr;
    sa_start_t   start;
    sa_rd_req_t  rd_req;
    sa_rd_rsp_t  rd_rsp;
    logic        busy;
    logic        done;

    // operand matrices as the model sees them
    logic [`SA_DATA_W-1:0] a_mat [`SA_DIM][`SA_DEPTH];
    logic [`SA_DATA_W-1:0] b_mat [`SA_DEPTH][`SA_DIM];

    int seed;
    int error_count;
    int check_count;

    sa_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr     (wr),
        .i_start  (start),
        .i_rd_req (rd_req),
        .o_rd_rsp (rd_rsp),
        .o_busy   (busy),
        .o_done   (done)
    );

    always #10 clk = ~clk;  // 20 ns period

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [`SA_DATA_W-1:0] rand_operand();
        int v;
        v = $random(seed);
        return v[`SA_DATA_W-1:0];
    endfunction

    // row r of C with wrap at acc width
    function automatic sa_acc_vec_t model_row(int r, int k_len);
        sa_acc_vec_t acc;
        acc = '0;
        for (int k = 0; k < k_len; k++)
            for (int c = 0; c < `SA_DIM; c++)
                acc[c] = acc[c] + `SA_ACC_W'(a_mat[r][k]) * `SA_ACC_W'(b_mat[k][c]);
        return acc;
    endfunction

    task automatic check_value(string name, logic [`SA_ACC_W-1:0] got,
                               logic [`SA_ACC_W-1:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic abort_run(string why);
        error_count++;
        $display("timeout: %s", why);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Verification failed");
        $finish;
    endtask

    // ------------------------------
    // write, run, read and check
    // ------------------------------
    task automatic write_operands(int k_len);
        sa_vec_t col;
        sa_vec_t row;
        for (int k = 0; k < k_len; k++)
        begin
            for (int i = 0; i < `SA_DIM; i++)
            begin
                col[i] = a_mat[i][k];  // left bank holds A columns
                row[i] = b_mat[k][i];
            end
            @(posedge clk);
            wr <= '{en: 1'b1, bank: BANK_LEFT, addr: `SA_ADDR_W'(k), data: col};
            @(posedge clk);
            wr <= '{en: 1'b1, bank: BANK_TOP, addr: `SA_ADDR_W'(k), data: row};
        end
        @(posedge clk);
        wr <= '0;
    endtask

    // disturb injects a start and a left bank write while busy
    task automatic run_and_wait(int k_len, bit disturb);
        int cycles;
        @(posedge clk);
        start <= '{start: 1'b1, len: LEN_W'(k_len)};
        @(posedge clk);
        start <= '0;
        @(negedge clk);
        check_value("o_busy", busy, 1);
        cycles = 0;
        while (!done && cycles < RUN_TIMEOUT)
        begin
            @(posedge clk);
            if (disturb && cycles == 2)
            begin
                start <= '{start: 1'b1, len: LEN_W'(1)};
                wr    <= '{en: 1'b1, bank: BANK_LEFT, addr: '0, data: '1};
            end
            else if (disturb && cycles == 3)
            begin
                start <= '0;
                wr    <= '0;
            end
            @(negedge clk);
            cycles++;
        end
        if (!done)
            abort_run($sformatf("o_done did not pulse within %0d cycles", RUN_TIMEOUT));
        else
        begin
            check_value("o_busy", busy, 0);  // drops with done
            repeat (2 * `SA_DIM)
            begin
                @(negedge clk);
                check_value("o_done", done, 0);
                check_value("o_busy", busy, 0);
            end
        end
    endtask

    task automatic read_row(int row, output sa_acc_vec_t got);
        int cycles;
        @(posedge clk);
        rd_req <= '{en: 1'b1, addr: `SA_ADDR_W'(row)};
        @(negedge clk);
        check_value("o_rd_rsp.valid", rd_rsp.valid, 0);
        @(posedge clk);
        rd_req <= '0;
        cycles = 1;
        @(negedge clk);
        while (!rd_rsp.valid && cycles < READ_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        got = rd_rsp.data;
        if (!rd_rsp.valid)
            abort_run($sformatf("no read response for row %0d", row));
        else
        begin
            check_count++;
            assert (cycles == 1)
            else
            begin
                $display("read response for row %0d came %0d cycles after the request",
                         row, cycles);
                error_count++;
            end
        end
    endtask

    task automatic check_result(int k_len);
        sa_acc_vec_t got;
        sa_acc_vec_t exp;
        for (int r = 0; r < `SA_DIM; r++)
        begin
            read_row(r, got);
            exp = model_row(r, k_len);
            for (int c = 0; c < `SA_DIM; c++)
                check_value($sformatf("o_rd_rsp.data[%0d] row %0d", c, r), got[c], exp[c]);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic idle_after_reset();
        @(negedge clk);
        check_value("o_busy", busy, 0);
        check_value("o_done", done, 0);
        check_value("o_rd_rsp.valid", rd_rsp.valid, 0);
    endtask

    task automatic identity_passthrough();
        for (int r = 0; r < `SA_DIM; r++)
            for (int k = 0; k < `SA_DIM; k++)
            begin
                a_mat[r][k] = `SA_DATA_W'(r == k);
                b_mat[k][r] = rand_operand();
            end
        write_operands(`SA_DIM);
        run_and_wait(`SA_DIM, 1'b0);
        check_result(`SA_DIM);  // row r is B row r
    endtask

    task automatic random_full_depth();
        for (int k = 0; k < `SA_DEPTH; k++)
            for (int i = 0; i < `SA_DIM; i++)
            begin
                a_mat[i][k] = rand_operand();
                b_mat[k][i] = rand_operand();
            end
        write_operands(`SA_DEPTH);
        run_and_wait(`SA_DEPTH, 1'b0);
        check_result(`SA_DEPTH);
    endtask

    task automatic single_step_outer();
        for (int i = 0; i < `SA_DIM; i++)
        begin
            a_mat[i][0] = rand_operand();
            b_mat[0][i] = rand_operand();
        end
        write_operands(1);
        run_and_wait(1, 1'b0);  // old sums must be gone
        check_result(1);
    endtask

    task automatic busy_guard();
        for (int k = 0; k < `SA_DIM; k++)
            for (int i = 0; i < `SA_DIM; i++)
            begin
                a_mat[i][k] = rand_operand();
                b_mat[k][i] = rand_operand();
            end
        write_operands(`SA_DIM);
        run_and_wait(`SA_DIM, 1'b1);
        check_result(`SA_DIM);
        run_and_wait(`SA_DIM, 1'b0);  // operands still untouched
        check_result(`SA_DIM);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wr          = '0;
        start       = '0;
        rd_req      = '0;
        seed        = 32'hccf1_5835;
        error_count = 0;
        check_count = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        idle_after_reset();
        identity_passthrough();
        random_full_depth();
        single_step_outer();
        busy_guard();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== systolic_array.f ====
+incdir+hdl
hdl/sa_pkg.sv
hdl/sa_operand_bank.sv
hdl/sa_mac_cell.sv
hdl/sa_mac_grid.sv
hdl/sa_result_bank.sv
hdl/sa_controller.sv
hdl/sa_top.sv
sim/sa_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sa_tb
FILELIST  ?= systolic_array.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
